//--- fdc_pkg.sv
// fdc shared package holding register bit positions, command codes, status codes and bus records
`default_nettype none

package fdc_pkg;

	localparam int NUM_DRIVES = 2;

	// ========================================
	// main status register bit positions
	// ========================================
	localparam int MSR_D0B = 0; // drive 0 seeking
	localparam int MSR_D1B = 1; // drive 1 seeking
	localparam int MSR_CB  = 4; // command in progress
	localparam int MSR_EXM = 5; // no execution phase here
	localparam int MSR_DIO = 6; // 1 = controller to host
	localparam int MSR_RQM = 7;

	// ========================================
	// command codes, low five bits of the command byte
	// ========================================
	localparam logic [4:0] OPC_SPECIFY     = 5'b00011;
	localparam logic [4:0] OPC_SENSE_DRIVE = 5'b00100;
	localparam logic [4:0] OPC_RECALIBRATE = 5'b00111;
	localparam logic [4:0] OPC_SENSE_INT   = 5'b01000;
	localparam logic [4:0] OPC_SEEK        = 5'b01111;

	// status register 0 codes with the drive number ORed into bit 0
	localparam logic [7:0] ST0_SEEK_OK_BASE  = 8'h20;
	localparam logic [7:0] ST0_SEEK_ERR_BASE = 8'he8; // abnormal end with seek end and not ready
	localparam logic [7:0] ST0_INVALID       = 8'h80;

	// host bus event toward the command controller
	typedef struct packed {
		logic       wr_stb; // data register write
		logic       rd_stb; // data register read
		logic [7:0] data;
	} host_ev_t;

	// controller request to one head stepper
	typedef struct packed {
		logic       go;
		logic       clr_int;
		logic [7:0] ncn; // new cylinder number
	} seek_req_t;

	// head stepper status back to the controller
	typedef struct packed {
		logic       busy;
		logic       int_pending;
		logic       seek_ok;
		logic [7:0] pcn; // present cylinder number
	} drive_state_t;

endpackage

`default_nettype wire

//--- fdc_host_port.sv
// fdc host port that samples the nRD/nWR/a0 bus into strobes and selects the read data
`timescale 1ns/1ps
`default_nettype none

module fdc_host_port (
	input  logic              i_clk_sys,
	input  logic              i_reset,
	input  logic              i_nrd,
	input  logic              i_nwr,
	input  logic              i_a0,
	input  logic [7:0]        i_din,
	input  logic [7:0]        i_msr,
	input  logic [7:0]        i_data_reg,
	output fdc_pkg::host_ev_t o_ev,
	output logic [7:0]        o_dout
);

	logic       nrd_q;
	logic       nwr_q;
	logic       a0_q;
	logic [7:0] din_q;
	logic       rd_lvl;
	logic       wr_lvl;
	logic       rd_old;
	logic       wr_old;
	logic       rd_stb_q;
	logic       wr_stb_q;
	logic [7:0] data_q;

	assign rd_lvl = nwr_q & ~nrd_q; // read only when write is idle
	assign wr_lvl = ~nwr_q & nrd_q;

	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			nrd_q    <= 1'b1;
			nwr_q    <= 1'b1;
			a0_q     <= 1'b0;
			rd_old   <= 1'b0;
			wr_old   <= 1'b0;
			rd_stb_q <= 1'b0;
			wr_stb_q <= 1'b0;
		end else begin
			nrd_q    <= i_nrd;
			nwr_q    <= i_nwr;
			a0_q     <= i_a0;
			rd_old   <= rd_lvl;
			wr_old   <= wr_lvl;
			rd_stb_q <= rd_lvl & ~rd_old & a0_q; // only the data register
			wr_stb_q <= wr_lvl & ~wr_old & a0_q;
		end
	end

	// write data travels with the strobe
	always_ff @(posedge i_clk_sys) begin
		din_q <= i_din;
		if (wr_lvl & ~wr_old)
			data_q <= din_q;
	end

	assign o_ev   = '{wr_stb: wr_stb_q, rd_stb: rd_stb_q, data: data_q};
	assign o_dout = i_a0 ? i_data_reg : i_msr;

endmodule

`default_nettype wire

//--- fdc_head_stepper.sv
// fdc head stepper for one drive, tracks the cylinder and times each step of a seek
`timescale 1ns/1ps
`default_nettype none

module fdc_head_stepper #(
	parameter int CYCLES_PER_MS = 4000,
	parameter int NUM_CYLINDERS = 40
) (
	input  logic                  i_clk_sys,
	input  logic                  i_reset,
	input  fdc_pkg::seek_req_t    i_req,
	input  logic [3:0]            i_srt,
	input  logic                  i_motor,
	input  logic                  i_ready,
	output fdc_pkg::drive_state_t o_state
);

	// wide enough for the slowest step rate
	localparam int TMR_W = $clog2(16 * CYCLES_PER_MS + 1);

	logic             busy;
	logic             int_pending;
	logic             seek_ok;
	logic [7:0]       pcn;
	logic [7:0]       ncn;
	logic [TMR_W-1:0] step_tmr;
	logic [TMR_W-1:0] step_period;
	logic             target_ok;

	// srt 15 gives 1 ms per step, srt 0 gives 16 ms
	assign step_period = TMR_W'((16 - int'(i_srt)) * CYCLES_PER_MS);

	// track 0 is always reachable
	assign target_ok = (i_req.ncn == 8'd0) ||
		(i_motor && i_ready && (int'(i_req.ncn) < NUM_CYLINDERS));

	// ========================================
	// seek sequencer
	// ========================================
	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			busy        <= 1'b0;
			int_pending <= 1'b0;
			seek_ok     <= 1'b0;
			pcn         <= 8'd0;
			step_tmr    <= '0;
		end else if (i_req.go) begin
			ncn      <= i_req.ncn;
			step_tmr <= '0;
			if (target_ok) begin
				busy        <= 1'b1;
				int_pending <= 1'b0;
			end else begin
				busy        <= 1'b0; // report a rejected seek at once
				int_pending <= 1'b1;
				seek_ok     <= 1'b0;
			end
		end else begin
			if (i_req.clr_int)
				int_pending <= 1'b0;
			if (busy) begin
				if (step_tmr != '0) begin
					step_tmr <= step_tmr - 1'b1;
				end else if (pcn == ncn) begin
					busy        <= 1'b0;
					int_pending <= 1'b1;
					seek_ok     <= i_ready; // clear if the drive dropped out during the seek
				end else begin
					if (pcn > ncn)
						pcn <= pcn - 8'd1;
					else
						pcn <= pcn + 8'd1;
					step_tmr <= step_period - 1'b1;
				end
			end
		end
	end

	assign o_state = '{
		busy:        busy,
		int_pending: int_pending,
		seek_ok:     seek_ok,
		pcn:         pcn
	};

endmodule

`default_nettype wire

//--- fdc_cmd_ctrl.sv
// fdc command controller that decodes commands, gathers parameters and serves result bytes
`timescale 1ns/1ps
`default_nettype none

module fdc_cmd_ctrl (
	input  logic                                           i_clk_sys,
	input  logic                                           i_reset,
	input  fdc_pkg::host_ev_t                              i_ev,
	input  fdc_pkg::drive_state_t [fdc_pkg::NUM_DRIVES-1:0] i_drv,
	input  logic [fdc_pkg::NUM_DRIVES-1:0]                 i_available,
	input  logic [fdc_pkg::NUM_DRIVES-1:0]                 i_wp,
	input  logic [fdc_pkg::NUM_DRIVES-1:0]                 i_two_sided,
	input  logic [fdc_pkg::NUM_DRIVES-1:0]                 i_ready,
	output fdc_pkg::seek_req_t [fdc_pkg::NUM_DRIVES-1:0]    o_req,
	output logic [3:0]                                     o_srt,
	output logic [7:0]                                     o_msr,
	output logic [7:0]                                     o_data_reg
);
	import fdc_pkg::*;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_SPECIFY1,
		ST_SPECIFY2,
		ST_RECAL,
		ST_SEEK_DRV,
		ST_SEEK_NCN,
		ST_SENSE_DRV,
		ST_SENSE_DRV_RD,
		ST_SENSE_INT_ST0,
		ST_SENSE_INT_PCN,
		ST_INVALID
	} state_t;

	state_t                state;
	logic                  sel_drv;  // drive of the current command
	logic                  sel_head;
	logic                  sis_drv;  // drive being reported by sense interrupt
	logic [NUM_DRIVES-1:0] req_go;
	logic [NUM_DRIVES-1:0] req_clr;
	logic [7:0]            req_ncn [NUM_DRIVES];
	logic                  result_phase;
	logic                  sis_pend;
	logic                  sis_sel;
	logic [7:0]            sis_st0;
	logic [7:0]            st3;

	// lowest pending drive answers first
	assign sis_pend = i_drv[0].int_pending | i_drv[1].int_pending;
	assign sis_sel  = ~i_drv[0].int_pending;
	assign sis_st0  = (i_drv[sis_sel].seek_ok ? ST0_SEEK_OK_BASE : ST0_SEEK_ERR_BASE) |
		{7'd0, sis_sel};

	assign st3 = {
		1'b0,
		i_wp[sel_drv] & i_ready[sel_drv],
		i_available[sel_drv],
		i_drv[sel_drv].pcn == 8'd0, // track 0
		i_two_sided[sel_drv],
		sel_head,
		1'b0,
		sel_drv
	};

	assign result_phase = state inside {ST_SENSE_DRV_RD, ST_SENSE_INT_ST0,
		ST_SENSE_INT_PCN, ST_INVALID};

	// ========================================
	// main status register
	// ========================================
	always_comb begin
		o_msr          = 8'h00;
		o_msr[MSR_D0B] = i_drv[0].busy;
		o_msr[MSR_D1B] = i_drv[1].busy;
		o_msr[MSR_CB]  = (state != ST_IDLE);
		o_msr[MSR_EXM] = 1'b0;
		o_msr[MSR_DIO] = result_phase;
		o_msr[MSR_RQM] = 1'b1; // host never has to wait
	end

	// ========================================
	// command state machine
	// ========================================
	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			state   <= ST_IDLE;
			o_srt   <= 4'd4;
			req_go  <= '0;
			req_clr <= '0;
		end else begin
			req_go  <= '0; // single cycle pulses
			req_clr <= '0;
			case (state)
				ST_IDLE: if (i_ev.wr_stb) begin
					if (i_ev.data[7:5] != 3'b000) begin
						state   <= ST_INVALID;
						req_clr <= '1;
					end else begin
						case (i_ev.data[4:0])
							OPC_SPECIFY: begin
								state   <= ST_SPECIFY1;
								req_clr <= '1;
							end
							OPC_SENSE_DRIVE: begin
								state   <= ST_SENSE_DRV;
								req_clr <= '1;
							end
							OPC_RECALIBRATE: state <= ST_RECAL;
							OPC_SENSE_INT:   state <= ST_SENSE_INT_ST0;
							OPC_SEEK:        state <= ST_SEEK_DRV;
							default: begin
								state   <= ST_INVALID;
								req_clr <= '1;
							end
						endcase
					end
				end
				ST_SPECIFY1: if (i_ev.wr_stb) begin
					o_srt <= i_ev.data[7:4]; // head unload time ignored
					state <= ST_SPECIFY2;
				end
				ST_SPECIFY2: if (i_ev.wr_stb) state <= ST_IDLE; // head load byte
				ST_RECAL: if (i_ev.wr_stb) begin
					req_go[i_ev.data[0]]  <= 1'b1;
					req_ncn[i_ev.data[0]] <= 8'd0;
					state                 <= ST_IDLE;
				end
				ST_SEEK_DRV: if (i_ev.wr_stb) begin
					sel_drv <= i_ev.data[0];
					state   <= ST_SEEK_NCN;
				end
				ST_SEEK_NCN: if (i_ev.wr_stb) begin
					req_go[sel_drv]  <= 1'b1;
					req_ncn[sel_drv] <= i_ev.data;
					state            <= ST_IDLE;
				end
				ST_SENSE_DRV: if (i_ev.wr_stb) begin
					sel_drv  <= i_ev.data[0];
					sel_head <= i_ev.data[2];
					state    <= ST_SENSE_DRV_RD;
				end
				ST_SENSE_DRV_RD: if (i_ev.rd_stb) begin
					o_data_reg <= st3;
					state      <= ST_IDLE;
				end
				ST_SENSE_INT_ST0: if (i_ev.rd_stb) begin
					if (sis_pend) begin
						o_data_reg <= sis_st0;
						sis_drv    <= sis_sel;
						state      <= ST_SENSE_INT_PCN;
					end else begin
						o_data_reg <= ST0_INVALID; // nothing to report
						state      <= ST_IDLE;
					end
				end
				ST_SENSE_INT_PCN: if (i_ev.rd_stb) begin
					o_data_reg       <= i_drv[sis_drv].pcn;
					req_clr[sis_drv] <= 1'b1;
					state            <= ST_IDLE;
				end
				ST_INVALID: if (i_ev.rd_stb) begin
					o_data_reg <= ST0_INVALID;
					state      <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_DRIVES; i++) begin
			o_req[i].go      = req_go[i];
			o_req[i].clr_int = req_clr[i];
			o_req[i].ncn     = req_ncn[i];
		end
	end

endmodule

`default_nettype wire

//--- fdc_top.sv
// fdc top level joining the host port, the command controller and two head steppers
`timescale 1ns/1ps
`default_nettype none

module fdc_top #(
	parameter int CYCLES_PER_MS = 4000,
	parameter int NUM_CYLINDERS = 40
) (
	input  logic                           i_clk_sys,
	input  logic                           i_reset,
	input  logic                           i_nrd,
	input  logic                           i_nwr,
	input  logic                           i_a0,
	input  logic [7:0]                     i_din,
	output logic [7:0]                     o_dout,
	input  logic [fdc_pkg::NUM_DRIVES-1:0] i_ready,
	input  logic [fdc_pkg::NUM_DRIVES-1:0] i_motor,
	input  logic [fdc_pkg::NUM_DRIVES-1:0] i_available,
	input  logic [fdc_pkg::NUM_DRIVES-1:0] i_wp,
	input  logic [fdc_pkg::NUM_DRIVES-1:0] i_two_sided
);
	import fdc_pkg::*;

	host_ev_t                       host_ev;
	seek_req_t    [NUM_DRIVES-1:0]  seek_req;
	drive_state_t [NUM_DRIVES-1:0]  drv_state;
	logic         [3:0]             srt;      // shared step rate
	logic         [7:0]             msr;
	logic         [7:0]             data_reg;

	fdc_host_port u_host (
		.i_clk_sys  (i_clk_sys),
		.i_reset    (i_reset),
		.i_nrd      (i_nrd),
		.i_nwr      (i_nwr),
		.i_a0       (i_a0),
		.i_din      (i_din),
		.i_msr      (msr),
		.i_data_reg (data_reg),
		.o_ev       (host_ev),
		.o_dout     (o_dout)
	);

	fdc_cmd_ctrl u_ctrl (
		.i_clk_sys   (i_clk_sys),
		.i_reset     (i_reset),
		.i_ev        (host_ev),
		.i_drv       (drv_state),
		.i_available (i_available),
		.i_wp        (i_wp),
		.i_two_sided (i_two_sided),
		.i_ready     (i_ready),
		.o_req       (seek_req),
		.o_srt       (srt),
		.o_msr       (msr),
		.o_data_reg  (data_reg)
	);

	// ========================================
	// one stepper per drive
	// ========================================
	fdc_head_stepper #(
		.CYCLES_PER_MS (CYCLES_PER_MS),
		.NUM_CYLINDERS (NUM_CYLINDERS)
	) u_step0 (
		.i_clk_sys (i_clk_sys),
		.i_reset   (i_reset),
		.i_req     (seek_req[0]),
		.i_srt     (srt),
		.i_motor   (i_motor[0]),
		.i_ready   (i_ready[0]),
		.o_state   (drv_state[0])
	);

	fdc_head_stepper #(
		.CYCLES_PER_MS (CYCLES_PER_MS),
		.NUM_CYLINDERS (NUM_CYLINDERS)
	) u_step1 (
		.i_clk_sys (i_clk_sys),
		.i_reset   (i_reset),
		.i_req     (seek_req[1]),
		.i_srt     (srt),
		.i_motor   (i_motor[1]),
		.i_ready   (i_ready[1]),
		.o_state   (drv_state[1])
	);

endmodule

`default_nettype wire

//--- tb_fdc.sv
// fdc testbench that runs command sequences over the host bus and checks every result byte
`timescale 1ns/1ps
`default_nettype none

module tb_fdc;
	import fdc_pkg::*;

	localparam int CYCLES_PER_MS  = 4;
	localparam int NUM_CYLINDERS  = 40;
	localparam int STEP_CYCLES    = (16 - 14) * CYCLES_PER_MS; // step rate 14
	localparam int TIMEOUT_CYCLES = 20000; // covers 12 seeks of up to 63 steps plus bus traffic

	logic        clk_sys;
	logic        reset;
	logic        nrd;
	logic        nwr;
	logic        a0;
	logic [7:0]  din;
	logic [7:0]  dout;
	logic [1:0]  ready;
	logic [1:0]  motor;
	logic [1:0]  available;
	logic [1:0]  wp;
	logic [1:0]  two_sided;
	logic [31:0] lfsr;
	logic [7:0]  model_pcn [2];
	logic        model_ok [2];
	logic        model_pend [2];
	int          errors;
	int          checks;
	int          cycles = 0;

	fdc_top #(
		.CYCLES_PER_MS (CYCLES_PER_MS),
		.NUM_CYLINDERS (NUM_CYLINDERS)
	) UUT (
		.i_clk_sys   (clk_sys),
		.i_reset     (reset),
		.i_nrd       (nrd),
		.i_nwr       (nwr),
		.i_a0        (a0),
		.i_din       (din),
		.o_dout      (dout),
		.i_ready     (ready),
		.i_motor     (motor),
		.i_available (available),
		.i_wp        (wp),
		.i_two_sided (two_sided)
	);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = 8'd0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[6:0], lfsr[0]};
		end
	endtask

	// ========================================
	// reference model
	// ========================================
	function automatic void model_seek(input logic drv, input logic [7:0] ncn);
		if (ncn == 8'd0 || (motor[drv] && ready[drv] && int'(ncn) < NUM_CYLINDERS)) begin
			model_pcn[drv] = ncn;
			model_ok[drv]  = ready[drv];
		end else begin
			model_ok[drv] = 1'b0; // head stays put on a rejected seek
		end
		model_pend[drv] = 1'b1;
	endfunction

	// kind 0 is st0, 1 is pcn, anything else is st3
	function automatic logic [7:0] ref_byte(input int kind, input logic drv, input logic head);
		logic       sel;
		logic [7:0] st0;
		sel = !model_pend[0]; // lowest pending drive
		st0 = (model_ok[sel] ? 8'h20 : 8'he8) | {7'd0, sel};
		case (kind)
			0:       ref_byte = (model_pend[0] || model_pend[1]) ? st0 : 8'h80;
			1:       ref_byte = model_pcn[sel];
			default: ref_byte = {1'b0, wp[drv] & ready[drv], available[drv],
				model_pcn[drv] == 8'd0, two_sided[drv], head, 1'b0, drv};
		endcase
	endfunction

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got 0x%02h, expected 0x%02h", name, got, exp);
		end
	endtask

	// ========================================
	// host bus
	// ========================================
	task automatic bus_write(input logic a0_val, input logic [7:0] data);
		@(posedge clk_sys);
		a0  <= a0_val;
		din <= data;
		nwr <= 1'b0;
		repeat (4) @(posedge clk_sys);
		nwr <= 1'b1;
		@(posedge clk_sys);
	endtask

	task automatic bus_read(input logic a0_val, output logic [7:0] data);
		@(posedge clk_sys);
		a0  <= a0_val;
		nrd <= 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys); // data register settled
		data = dout;
		@(posedge clk_sys);
		nrd <= 1'b1;
		@(posedge clk_sys);
	endtask

	task automatic poll_idle();
		logic [7:0] msr;
		msr = 8'hff;
		while (msr[MSR_D0B] || msr[MSR_D1B])
			bus_read(1'b0, msr);
	endtask

	task automatic send_seek(input logic drv, input logic [7:0] ncn);
		bus_write(1'b1, {3'b000, OPC_SEEK});
		bus_write(1'b1, {7'd0, drv});
		bus_write(1'b1, ncn);
		model_seek(drv, ncn);
	endtask

	task automatic sense_int();
		logic [7:0] v;
		logic       sel;
		bus_write(1'b1, {3'b000, OPC_SENSE_INT});
		bus_read(1'b1, v);
		check_byte("sis_st0", v, ref_byte(0, 1'b0, 1'b0));
		if (model_pend[0] || model_pend[1]) begin
			sel = !model_pend[0];
			bus_read(1'b1, v);
			check_byte("sis_pcn", v, ref_byte(1, 1'b0, 1'b0));
			model_pend[sel] = 1'b0;
		end
	endtask

	task automatic sense_drive(input logic drv, input logic head);
		logic [7:0] v;
		bus_write(1'b1, {3'b000, OPC_SENSE_DRIVE});
		bus_write(1'b1, {5'd0, head, 1'b0, drv});
		model_pend[0] = 1'b0; // command drops all pending interrupts
		model_pend[1] = 1'b0;
		bus_read(1'b1, v);
		check_byte("st3", v, ref_byte(2, drv, head));
	endtask

	initial begin
		logic [7:0] v;
		logic [7:0] tgt;
		logic [7:0] pick;
		logic [7:0] head;
		int         t0;
		clk_sys   = 1'b0;
		reset     <= 1'b1;
		nrd       <= 1'b1;
		nwr       <= 1'b1;
		a0        <= 1'b0;
		din       <= 8'h00;
		ready     <= 2'b11;
		motor     <= 2'b11;
		available <= 2'b11;
		wp        <= 2'b00;
		two_sided <= 2'b00;
		lfsr      = 32'h82a1_3f2f;
		errors    = 0;
		checks    = 0;
		for (int i = 0; i < 2; i++) begin
			model_pcn[i]  = 8'd0;
			model_ok[i]   = 1'b0;
			model_pend[i] = 1'b0;
		end
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;

		bus_read(1'b0, v);
		check_byte("msr_reset", v, 8'h80);
		sense_int();

		// step rate 14 means 2 ms per step
		bus_write(1'b1, {3'b000, OPC_SPECIFY});
		bus_write(1'b1, 8'he0);
		bus_write(1'b1, 8'h02);
		take_bits(6, pick);
		tgt = (pick % 8'd39) + 8'd1;
		send_seek(1'b0, tgt);
		t0 = cycles;
		bus_read(1'b0, v);
		check_byte("msr_d0b", {7'd0, v[MSR_D0B]}, 8'h01);
		poll_idle();
		// the default step rate would take six times as long
		check_byte("seek_in_time",
			{7'd0, (cycles - t0) <= int'(tgt) * STEP_CYCLES + 16}, 8'h01);
		sense_int();
		sense_int();

		@(posedge clk_sys);
		motor <= 2'b01;
		send_seek(1'b1, 8'd5);
		poll_idle();
		sense_int();
		@(posedge clk_sys);
		motor <= 2'b11;
		send_seek(1'b1, 8'd45); // beyond the last cylinder
		poll_idle();
		sense_int();

		@(posedge clk_sys);
		wp        <= 2'b01;
		two_sided <= 2'b01;
		available <= 2'b10;
		bus_write(1'b1, {3'b000, OPC_RECALIBRATE});
		bus_write(1'b1, 8'h00);
		model_seek(1'b0, 8'd0);
		poll_idle();
		sense_int();
		sense_drive(1'b0, 1'b1);

		bus_write(1'b1, 8'h06);
		model_pend[0] = 1'b0;
		model_pend[1] = 1'b0;
		bus_read(1'b0, v);
		check_byte("msr_result", v, 8'hd0);
		bus_read(1'b1, v);
		check_byte("invalid_st0", v, 8'h80);
		bus_read(1'b0, v);
		check_byte("msr_idle", v, 8'h80);

		// random seeks that may pass the last cylinder
		repeat (8) begin
			take_bits(1, pick);
			take_bits(6, tgt);
			take_bits(1, head);
			send_seek(pick[0], tgt);
			poll_idle();
			sense_int();
			sense_drive(pick[0], head[0]);
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
fdc_pkg.sv
fdc_host_port.sv
fdc_head_stepper.sv
fdc_cmd_ctrl.sv
fdc_top.sv
tb_fdc.sv

//--- run_sim.sh
#!/bin/sh
# build the fdc testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module tb_fdc -o tb_fdc_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_fdc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
